//--- rpi_bus_pkg.sv
// --------------------------------------
// host bus constants and the command word
// that the bus port hands to the assembler
// import inside the module body where used
// --------------------------------------

package rpi_bus_pkg;

	// --------------------------------------
	// bus geometry
	// --------------------------------------

	// width of the half-duplex host bus
	localparam int bus_width = 16;

	// one memory word as the host sees it
	localparam int data_width = 32;

	// bus transactions needed to move one memory word
	// upper half goes first
	localparam int transactions_per_data_word = data_width / bus_width;

	// --------------------------------------
	// decoded host transaction
	// --------------------------------------

	// captured once per rising edge of synced enable
	// is_read mirrors the read line (0=write, 1=read)
	// is_data mirrors register_select (0=address, 1=data)
	typedef struct packed {
		logic is_read;
		logic is_data;
		logic [bus_width-1:0] value;
	} bus_cmd_t;

endpackage

//--- mem_map_pkg.sv
// --------------------------------------
// address map of the banked memory and the
// request word passed down the pipeline
// --------------------------------------

package mem_map_pkg;

	// --------------------------------------
	// address map
	// --------------------------------------

	// bank field sits in the top bits of the address word
	localparam int bank_bits = 3;
	// word inside a bank, 8k deep
	localparam int word_addr_bits = 13;
	localparam int number_of_banks = 1 << bank_bits;
	// index of the current bus transaction within a data word
	localparam int half_bits = $clog2(rpi_bus_pkg::transactions_per_data_word);

	// same layout as the 16-bit host address word
	typedef struct packed {
		logic [bank_bits-1:0] bank;
		logic [word_addr_bits-1:0] word;
	} addr_t;

	// --------------------------------------
	// pipeline request
	// --------------------------------------

	typedef enum logic [1:0] {
		address_write,
		address_read,
		data_write,
		data_read
	} req_kind_t;

	// one per host transaction, valid for a single cycle
	typedef struct packed {
		req_kind_t kind;
		addr_t addr;
		logic [rpi_bus_pkg::data_width-1:0] write_word;
		logic [half_bits-1:0] half;
		logic valid;
	} mem_req_t;

endpackage

//--- rpi_bus_port.sv
// --------------------------------------
// host side of the half-duplex bus
// syncs the control lines, turns each enable
// into one command and runs ack_valid
// --------------------------------------

module rpi_bus_port (
	input logic clock,
	input logic rst,
	input logic [rpi_bus_pkg::bus_width-1:0] bus_in,
	input logic read,
	input logic register_select,
	input logic enable,
	input logic done,
	output rpi_bus_pkg::bus_cmd_t cmd,
	output logic cmd_valid,
	output logic ack_valid,
	output logic synced_enable
);
	// two-flop synchronisers, bit 1 is the safe one
	logic [1:0] enable_sync;
	logic [1:0] read_sync;
	logic [1:0] register_select_sync;
	// last synced enable, for edge detect
	logic enable_prev;
	logic enable_rise;

	assign synced_enable = enable_sync[1];
	assign enable_rise = enable_sync[1] & ~enable_prev;

	// --------------------------------------
	// control
	// --------------------------------------

	always_ff @(posedge clock) begin
		if (rst) begin
			enable_sync <= '0;
			read_sync <= '0;
			register_select_sync <= '0;
			enable_prev <= 1'b0;
			cmd_valid <= 1'b0;
			ack_valid <= 1'b0;
		end else begin
			enable_sync <= {enable_sync[0], enable};
			read_sync <= {read_sync[0], read};
			register_select_sync <= {register_select_sync[0], register_select};
			enable_prev <= enable_sync[1];
			// one command per host enable
			cmd_valid <= enable_rise;
			// ack once the pipeline reports back
			if (done) begin
				ack_valid <= 1'b1;
			end else if (!enable_sync[1]) begin
				// host has let go, finish the exchange
				ack_valid <= 1'b0;
			end
		end
	end

	// --------------------------------------
	// command capture
	// --------------------------------------

	// host holds bus and controls steady while enable is high
	always_ff @(posedge clock) begin
		if (enable_rise) begin
			cmd.is_read <= read_sync[1];
			cmd.is_data <= register_select_sync[1];
			cmd.value <= bus_in;
		end
	end

endmodule

//--- word_assembler.sv
// --------------------------------------
// keeps the address register and the half
// index, builds write words from two bus
// halves and issues one request per command
// --------------------------------------

module word_assembler #(
	parameter bit address_autoincrement = 1'b1
) (
	input logic clock,
	input logic rst,
	input rpi_bus_pkg::bus_cmd_t cmd,
	input logic cmd_valid,
	output mem_map_pkg::mem_req_t req
);
	import rpi_bus_pkg::*;
	import mem_map_pkg::*;

	// current address and transaction index inside the data word
	addr_t addr_q;
	logic [half_bits-1:0] half_q;
	logic last_half;
	req_kind_t cmd_kind;

	// upper half waiting for its partner
	logic [bus_width-1:0] upper_half;

	// request registers
	logic req_valid;
	req_kind_t req_kind;
	addr_t req_addr;
	logic [data_width-1:0] req_word;
	logic [half_bits-1:0] req_half;

	assign last_half = (half_q == half_bits'(transactions_per_data_word - 1));

	// read and register_select straight to a kind
	always_comb begin
		case ({cmd.is_data, cmd.is_read})
			2'b00: cmd_kind = address_write;
			2'b01: cmd_kind = address_read;
			2'b10: cmd_kind = data_write;
			default: cmd_kind = data_read;
		endcase
	end

	// --------------------------------------
	// address and half index
	// --------------------------------------

	always_ff @(posedge clock) begin
		if (rst) begin
			addr_q <= '0;
			half_q <= '0;
			req_valid <= 1'b0;
		end else begin
			// every command goes down, so every enable gets a done
			req_valid <= cmd_valid;
			if (cmd_valid) begin
				if (cmd_kind == address_write) begin
					addr_q <= addr_t'(cmd.value);
					half_q <= '0;
				end else if (cmd_kind == data_write || cmd_kind == data_read) begin
					if (last_half) begin
						half_q <= '0;
						// word field wraps at 8k, bank is left alone
						if (address_autoincrement) begin
							addr_q.word <= addr_q.word + 1'b1;
						end
					end else begin
						half_q <= half_q + 1'b1;
					end
				end
			end
		end
	end

	// --------------------------------------
	// request payload
	// --------------------------------------

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			req_kind <= cmd_kind;
			req_half <= half_q;
			// address write carries the new address along
			req_addr <= (cmd_kind == address_write) ? addr_t'(cmd.value) : addr_q;
			req_word <= {upper_half, cmd.value};
			// first half of a write, hold it
			if (cmd_kind == data_write && half_q == '0) begin
				upper_half <= cmd.value;
			end
		end
	end

	assign req = '{kind: req_kind, addr: req_addr, write_word: req_word,
		half: req_half, valid: req_valid};

endmodule

//--- bank_router.sv
// --------------------------------------
// decodes the bank field into per-bank
// strobes, masked by the banks that exist
// --------------------------------------

module bank_router #(
	parameter logic [mem_map_pkg::number_of_banks-1:0] banks_present = 8'b1000_0001
) (
	input logic clock,
	input logic rst,
	input mem_map_pkg::mem_req_t req_in,
	output mem_map_pkg::mem_req_t req_out,
	output logic [mem_map_pkg::number_of_banks-1:0] write_strobe,
	output logic [mem_map_pkg::number_of_banks-1:0] read_strobe,
	output logic [mem_map_pkg::word_addr_bits-1:0] word_addr,
	output logic [rpi_bus_pkg::data_width-1:0] write_word
);
	import mem_map_pkg::*;

	logic [number_of_banks-1:0] bank_select;
	logic wants_write;
	logic wants_read;
	mem_req_t req_q;
	logic valid_q;

	// one-hot bank, absent banks drop out here
	assign bank_select = banks_present & (number_of_banks'(1) << req_in.addr.bank);
	// store only once both halves are in
	assign wants_write = req_in.valid && req_in.kind == data_write && req_in.half != '0;
	// RAM is read on the first half only
	assign wants_read = req_in.valid && req_in.kind == data_read && req_in.half == '0;

	always_ff @(posedge clock) begin
		if (rst) begin
			write_strobe <= '0;
			read_strobe <= '0;
			valid_q <= 1'b0;
		end else begin
			write_strobe <= wants_write ? bank_select : '0;
			read_strobe <= wants_read ? bank_select : '0;
			valid_q <= req_in.valid;
		end
	end

	// shared by every bank
	always_ff @(posedge clock) begin
		req_q <= req_in;
		word_addr <= req_in.addr.word;
		write_word <= req_in.write_word;
	end

	// request travels on to read_return alongside the strobes
	always_comb begin
		req_out = req_q;
		req_out.valid = valid_q;
	end

endmodule

//--- memory_bank.sv
// --------------------------------------
// one 8k x 32 bank, single port
// read data registered on read_strobe
// --------------------------------------

module memory_bank (
	input logic clock,
	input logic write_strobe,
	input logic read_strobe,
	input logic [mem_map_pkg::word_addr_bits-1:0] word_addr,
	input logic [rpi_bus_pkg::data_width-1:0] write_word,
	output logic [rpi_bus_pkg::data_width-1:0] read_word
);
	import rpi_bus_pkg::*;
	import mem_map_pkg::*;

	// maps onto block RAM
	logic [data_width-1:0] mem [2**word_addr_bits];

	always_ff @(posedge clock) begin
		if (write_strobe) begin
			mem[word_addr] <= write_word;
		end
		// output holds between reads
		if (read_strobe) begin
			read_word <= mem[word_addr];
		end
	end

endmodule

//--- read_return.sv
// --------------------------------------
// picks the read word, keeps it for the
// second half, drives the bus back to the
// host and reports done for every request
// --------------------------------------

module read_return (
	input logic clock,
	input logic rst,
	input mem_map_pkg::mem_req_t req,
	input logic [mem_map_pkg::number_of_banks-1:0][rpi_bus_pkg::data_width-1:0] bank_words,
	input logic enable_seen_low,
	input logic ack_valid,
	output logic [rpi_bus_pkg::bus_width-1:0] bus_out,
	output logic bus_oe,
	output logic done
);
	import rpi_bus_pkg::*;
	import mem_map_pkg::*;

	// request lined up with the RAM output
	mem_req_t req_q;
	logic valid_q;
	logic is_read;
	logic [data_width-1:0] selected_word;
	// whole word from the first half, for the second
	logic [data_width-1:0] held_word;

	assign is_read = (req_q.kind == address_read) || (req_q.kind == data_read);
	// absent banks come in as zero from the top
	assign selected_word = bank_words[req_q.addr.bank];

	// --------------------------------------
	// control
	// --------------------------------------

	always_ff @(posedge clock) begin
		if (rst) begin
			valid_q <= 1'b0;
			done <= 1'b0;
			bus_oe <= 1'b0;
		end else begin
			valid_q <= req.valid;
			done <= valid_q;
			// drive only for reads, release with ack
			if (valid_q && is_read) begin
				bus_oe <= 1'b1;
			end else if (enable_seen_low && ack_valid) begin
				bus_oe <= 1'b0;
			end
		end
	end

	// --------------------------------------
	// return data
	// --------------------------------------

	always_ff @(posedge clock) begin
		req_q <= req;
		if (valid_q) begin
			case (req_q.kind)
				address_read: begin
					bus_out <= req_q.addr;
				end
				data_read: begin
					if (req_q.half == '0) begin
						// upper half first
						held_word <= selected_word;
						bus_out <= selected_word[data_width-1 -: bus_width];
					end else begin
						bus_out <= held_word[bus_width-1:0];
					end
				end
				default: begin
					// writes return nothing
				end
			endcase
		end
	end

endmodule

//--- pollable_memory_top.sv
// --------------------------------------
// bus-attached banked memory, top level
// bus split into in, out and output enable
// only banks set in banks_present are built
// --------------------------------------

module pollable_memory_top #(
	parameter bit address_autoincrement = 1'b1,
	parameter logic [mem_map_pkg::number_of_banks-1:0] banks_present = 8'b1000_0001
) (
	input logic clock,
	input logic rst,
	input logic [rpi_bus_pkg::bus_width-1:0] bus_in,
	input logic read,
	input logic register_select,
	input logic enable,
	output logic [rpi_bus_pkg::bus_width-1:0] bus_out,
	output logic bus_oe,
	output logic ack_valid
);
	import rpi_bus_pkg::*;
	import mem_map_pkg::*;

	bus_cmd_t cmd;
	logic cmd_valid;
	logic synced_enable;
	logic done;
	mem_req_t assembled_req;
	mem_req_t routed_req;
	logic [number_of_banks-1:0] write_strobe;
	logic [number_of_banks-1:0] read_strobe;
	logic [word_addr_bits-1:0] word_addr;
	logic [data_width-1:0] write_word;
	logic [number_of_banks-1:0][data_width-1:0] bank_words;

	// --------------------------------------
	// pipeline, one cycle per stage
	// --------------------------------------

	rpi_bus_port port (
		.clock(clock), .rst(rst), .bus_in(bus_in), .read(read),
		.register_select(register_select), .enable(enable), .done(done),
		.cmd(cmd), .cmd_valid(cmd_valid), .ack_valid(ack_valid),
		.synced_enable(synced_enable)
	);

	word_assembler #(.address_autoincrement(address_autoincrement)) assembler (
		.clock(clock), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .req(assembled_req)
	);

	bank_router #(.banks_present(banks_present)) router (
		.clock(clock), .rst(rst), .req_in(assembled_req), .req_out(routed_req),
		.write_strobe(write_strobe), .read_strobe(read_strobe),
		.word_addr(word_addr), .write_word(write_word)
	);

	read_return returner (
		.clock(clock), .rst(rst), .req(routed_req), .bank_words(bank_words),
		.enable_seen_low(~synced_enable), .ack_valid(ack_valid),
		.bus_out(bus_out), .bus_oe(bus_oe), .done(done)
	);

	// --------------------------------------
	// banks
	// --------------------------------------

	for (genvar b = 0; b < number_of_banks; b++) begin : bank_slot
		if (banks_present[b]) begin : present
			memory_bank mem (
				.clock(clock), .write_strobe(write_strobe[b]), .read_strobe(read_strobe[b]),
				.word_addr(word_addr), .write_word(write_word), .read_word(bank_words[b])
			);
		end else begin : absent
			// missing bank reads back as zero
			assign bank_words[b] = '0;
		end
	end

endmodule

//--- tb_checker.sv
// ----------------------------------------
// watches the host bus of the DUT, keeps a
// model of address and memory, and compares
// every read returned at ack_valid
// ----------------------------------------

module tb_checker #(
	parameter bit address_autoincrement = 1'b1,
	parameter logic [mem_map_pkg::number_of_banks-1:0] banks_present = 8'b1000_0001
) (
	input logic clock,
	input logic rst,
	input logic [rpi_bus_pkg::bus_width-1:0] bus_in,
	input logic read,
	input logic register_select,
	input logic enable,
	input logic [rpi_bus_pkg::bus_width-1:0] bus_out,
	input logic bus_oe,
	input logic ack_valid,
	output int error_count,
	output int check_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// enable sampled high until ack sampled high
	localparam int ack_latency = 8;

	// model state
	logic [15:0] model_addr;
	logic model_half;
	logic [15:0] upper_half;
	logic [31:0] held_word;
	logic held_known;
	logic [31:0] model_mem [logic [15:0]];

	// transaction in flight
	logic [15:0] expected;
	logic expected_known;
	logic pending_read;
	logic enable_q;
	logic ack_q;
	int latency;

	// word field steps and the bank stays
	function automatic logic [15:0] next_address(input logic [15:0] addr);
		logic [15:0] result;
		result = addr;
		if (address_autoincrement) begin
			result[12:0] = addr[12:0] + 13'd1;
		end
		return result;
	endfunction

	task automatic update_model(input logic is_read, input logic is_data,
		input logic [15:0] value);
		expected_known = 1'b0;
		if (!is_data && !is_read) begin
			model_addr = value;
			model_half = 1'b0;
		end else if (!is_data) begin
			expected = model_addr;
			expected_known = 1'b1;
		end else if (!is_read) begin
			if (!model_half) begin
				upper_half = value;
				model_half = 1'b1;
			end else begin
				// absent banks drop the word
				if (banks_present[model_addr[15:13]]) begin
					model_mem[model_addr] = {upper_half, value};
				end
				model_half = 1'b0;
				model_addr = next_address(model_addr);
			end
		end else if (!model_half) begin
			held_known = 1'b1;
			if (!banks_present[model_addr[15:13]]) begin
				held_word = '0;
			end else if (model_mem.exists(model_addr)) begin
				held_word = model_mem[model_addr];
			end else begin
				// never written so nothing to compare
				held_known = 1'b0;
			end
			expected = held_word[31:16];
			expected_known = held_known;
			model_half = 1'b1;
		end else begin
			expected = held_word[15:0];
			expected_known = held_known;
			model_half = 1'b0;
			model_addr = next_address(model_addr);
		end
	endtask

	// ----------------------------------------
	// bus watch
	// ----------------------------------------

	always @(posedge clock) begin
		if (rst) begin
			model_addr = '0;
			model_half = 1'b0;
			held_known = 1'b0;
			enable_q = 1'b0;
			ack_q = 1'b0;
			latency = 0;
			error_count = 0;
			check_count = 0;
		end else begin
			latency = latency + 1;
			// new host transaction
			if (enable && !enable_q) begin
				latency = 0;
				pending_read = read;
				update_model(read, register_select, bus_in);
			end
			if (ack_valid && !ack_q) begin
				check_count = check_count + 1;
				if (latency != ack_latency) begin
					$display("** Error at %0t ns: ack_valid latency expected %0d, got %0d",
						$time, ack_latency, latency);
					error_count = error_count + 1;
				end
				if (pending_read && !bus_oe) begin
					$display("bus_oe was low at ack_valid of a read, time %0t ns", $time);
					error_count = error_count + 1;
				end else if (!pending_read && bus_oe) begin
					$display("bus_oe was driven at ack_valid of a write, time %0t ns", $time);
					error_count = error_count + 1;
				end
				if (pending_read && expected_known && bus_out !== expected) begin
					$display("** Error at %0t ns: bus_out expected %h, got %h",
						$time, expected, bus_out);
					error_count = error_count + 1;
				end
			end
			// ack may only drop once the host let go
			if (!ack_valid && ack_q && enable) begin
				$display("ack_valid fell while enable was still high, time %0t ns", $time);
				error_count = error_count + 1;
			end
			enable_q = enable;
			ack_q = ack_valid;
		end
	end

endmodule

//--- tb_pollable_memory.sv
// ----------------------------------------
// testbench top that runs random host
// transactions against the banked memory
// checked by tb_checker and bounded by a
// cycle limit
// ----------------------------------------

module tb_pollable_memory;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int operations = 400;
	// four transactions of twenty cycles each at most
	localparam int cycle_limit = operations * 4 * 20;
	localparam logic [7:0] banks_present = 8'b1000_0001;

	logic clock = 1'b0;
	logic rst;
	logic [15:0] bus_in;
	logic read;
	logic register_select;
	logic enable;
	logic [15:0] bus_out;
	logic bus_oe;
	logic ack_valid;
	int error_count;
	int check_count;
	int cycle_count = 0;

	// host side bookkeeping used to pick legal reads
	logic [15:0] current_addr;
	logic [15:0] written [$];

	always #50 clock = ~clock;

	pollable_memory_top #(.address_autoincrement(1'b1), .banks_present(banks_present)) DUT (
		.clock(clock), .rst(rst), .bus_in(bus_in), .read(read),
		.register_select(register_select), .enable(enable),
		.bus_out(bus_out), .bus_oe(bus_oe), .ack_valid(ack_valid)
	);

	tb_checker #(.address_autoincrement(1'b1), .banks_present(banks_present)) monitor (
		.clock(clock), .rst(rst), .bus_in(bus_in), .read(read),
		.register_select(register_select), .enable(enable), .bus_out(bus_out),
		.bus_oe(bus_oe), .ack_valid(ack_valid), .error_count(error_count),
		.check_count(check_count)
	);

	// ----------------------------------------
	// host transactions
	// ----------------------------------------

	// controls settle first and then the enable/ack_valid exchange runs
	task automatic host_transaction(input logic is_read, input logic is_data,
		input logic [15:0] value);
		@(posedge clock);
		read <= is_read;
		register_select <= is_data;
		bus_in <= value;
		@(posedge clock);
		enable <= 1'b1;
		do @(posedge clock); while (!ack_valid);
		enable <= 1'b0;
		do @(posedge clock); while (ack_valid);
	endtask

	task automatic set_address(input logic [15:0] addr);
		host_transaction(1'b0, 1'b0, addr);
		current_addr = addr;
	endtask

	task automatic store_word(input logic [31:0] word);
		host_transaction(1'b0, 1'b1, word[31:16]);
		host_transaction(1'b0, 1'b1, word[15:0]);
		if (banks_present[current_addr[15:13]]) begin
			written.push_back(current_addr);
		end
		current_addr[12:0] = current_addr[12:0] + 13'd1;
	endtask

	task automatic fetch_word();
		host_transaction(1'b1, 1'b1, 16'h0000);
		host_transaction(1'b1, 1'b1, 16'h0000);
		current_addr[12:0] = current_addr[12:0] + 13'd1;
	endtask

	// small word range so banks 0 and 7 collide
	// top of bank now and then for the wrap
	function automatic logic [15:0] random_address();
		logic [2:0] bank;
		logic [12:0] word;
		case ($urandom % 5)
			0, 1: bank = 3'd0;
			2, 3: bank = 3'd7;
			default: bank = 3'($urandom_range(6, 1));
		endcase
		if ($urandom % 8 == 0) begin
			word = 13'h1ffe + 13'($urandom % 2);
		end else begin
			word = 13'($urandom % 16);
		end
		return {bank, word};
	endfunction

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		int index;
		logic [15:0] target;
		void'($urandom(24392));
		rst = 1'b1;
		bus_in = '0;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		current_addr = '0;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		for (int op = 0; op < operations; op++) begin
			case ($urandom % 3)
				0: begin
					set_address(random_address());
					host_transaction(1'b1, 1'b0, 16'h0000);
				end
				1: begin
					store_word($urandom);
					// shows the autoincremented address
					host_transaction(1'b1, 1'b0, 16'h0000);
				end
				default: begin
					if (written.size() > 0 && $urandom % 4 != 0) begin
						index = int'($urandom % written.size());
						target = written[index];
					end else begin
						target = {3'($urandom_range(6, 1)), 13'($urandom % 16)};
					end
					set_address(target);
					fetch_word();
				end
			endcase
		end
		repeat (2) @(posedge clock);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a host transaction never completed",
				cycle_count);
			$display("tests failed");
			$finish;
		end
	end

endmodule

//--- compile.f
rpi_bus_pkg.sv
mem_map_pkg.sv
rpi_bus_port.sv
word_assembler.sv
bank_router.sv
memory_bank.sv
read_return.sv
pollable_memory_top.sv
tb_checker.sv
tb_pollable_memory.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_pollable_memory -f compile.f -o sim_pollable_memory

./obj_dir/sim_pollable_memory > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
